//--- soc_macros.svh
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// bus widths
`define SOC_ADDR_W      32
`define SOC_DATA_W      32
`define SOC_SEL_W       4
`define SOC_SLAVES      3
// register offset field inside a 4 KB peripheral window
`define SOC_OFS_W       12

// address map with mask = ~(end - base)
`define SRAM_BASE       32'h1A00_0000
`define SRAM_END        32'h1A00_03FF
`define SRAM_WORDS      256
`define GPIO_BASE       32'h1A10_0000
`define GPIO_END        32'h1A10_0FFF
`define UART_BASE       32'h1A10_1000
`define UART_END        32'h1A10_1FFF

`define GPIO_W          8
`define UART_DIV_RESET  16'd4
`define UART_DIV_W      16

// register offsets
`define GPIO_OUT_OFS    12'h000
`define GPIO_IN_OFS     12'h004
`define UART_DATA_OFS   12'h000
`define UART_DIV_OFS    12'h004
`define UART_STAT_OFS   12'h008

`endif

//--- soc_pkg.sv
`include "soc_macros.svh"

package soc_pkg;

  // wishbone classic request from the master
  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [`SOC_ADDR_W-1:0] adr;
    logic [`SOC_DATA_W-1:0] dat;
    logic [`SOC_SEL_W-1:0]  sel;
  } wb_req_t;

  // slave response with single-cycle ack and err pulses
  typedef struct packed {
    logic                   ack;
    logic                   err;
    logic [`SOC_DATA_W-1:0] dat;
  } wb_rsp_t;

  // slave numbering on the decoder ports
  typedef enum logic [1:0] {
    SLV_SRAM = 2'd0,
    SLV_GPIO = 2'd1,
    SLV_UART = 2'd2
  } slave_idx_t;

endpackage

//--- soc_bus_decoder.sv
`include "soc_macros.svh"

module soc_bus_decoder
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_n,
  input  wb_req_t m_req_i,
  output wb_rsp_t m_rsp_o,
  output wb_req_t s_req_o [`SOC_SLAVES],
  input  wb_rsp_t s_rsp_i [`SOC_SLAVES]
);

  logic [`SOC_ADDR_W-1:0] slv_base [`SOC_SLAVES];
  logic [`SOC_ADDR_W-1:0] slv_mask [`SOC_SLAVES];
  logic [`SOC_SLAVES-1:0] hit;
  logic [`SOC_SLAVES-1:0] slv_stb;
  logic                   any_hit;
  slave_idx_t             sel_idx;
  logic                   err_q;

  // address map table
  assign slv_base[SLV_SRAM] = `SRAM_BASE;
  assign slv_base[SLV_GPIO] = `GPIO_BASE;
  assign slv_base[SLV_UART] = `UART_BASE;
  assign slv_mask[SLV_SRAM] = ~(`SRAM_END - `SRAM_BASE);
  assign slv_mask[SLV_GPIO] = ~(`GPIO_END - `GPIO_BASE);
  assign slv_mask[SLV_UART] = ~(`UART_END - `UART_BASE);

  always_comb begin
    for (int k = 0; k < `SOC_SLAVES; k++) begin
      hit[k] = ((m_req_i.adr & slv_mask[k]) == slv_base[k]);
    end
  end

  assign any_hit = |hit;

  // matching slave index is valid only with any_hit
  always_comb begin
    sel_idx = SLV_SRAM;
    for (int k = 0; k < `SOC_SLAVES; k++) begin
      if (hit[k]) begin
        sel_idx = slave_idx_t'(k);
      end
    end
  end

  // only stb is steered while the rest is broadcast
  always_comb begin
    for (int k = 0; k < `SOC_SLAVES; k++) begin
      s_req_o[k]     = m_req_i;
      s_req_o[k].stb = m_req_i.stb & hit[k];
      slv_stb[k]     = s_req_o[k].stb;
    end
  end

  // unmapped access gets a one-cycle err one clock later
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      err_q <= 1'b0;
    end else begin
      err_q <= m_req_i.cyc & m_req_i.stb & ~any_hit & ~err_q;
    end
  end

  always_comb begin
    if (any_hit) begin
      m_rsp_o = s_rsp_i[sel_idx];
    end else begin
      m_rsp_o = '{ack: 1'b0, err: err_q, dat: '0};
    end
  end

  // no two slaves strobed and no slave strobed during an err
  a_one_target: assert property (
    @(posedge clk_i) disable iff (!reset_n)
    $onehot0({slv_stb, err_q})
  );

endmodule

//--- soc_sram.sv
`include "soc_macros.svh"

module soc_sram
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_n,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int AW = $clog2(`SRAM_WORDS);

  logic [`SOC_DATA_W-1:0] mem [`SRAM_WORDS];
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic [AW-1:0]          word_idx;
  logic                   access;
  logic                   ack_q;

  // word address without the byte offset bits
  assign word_idx = req_i.adr[AW+1:2];
  assign access   = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access && req_i.we) begin
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        if (req_i.sel[b]) begin
          mem[word_idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
        end
      end
    end
    if (access) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};

  // master holds stb until it samples ack
  a_ack_with_stb: assert property (
    @(posedge clk_i) disable iff (!reset_n)
    ack_q |-> req_i.stb
  );

endmodule

//--- soc_gpio.sv
`include "soc_macros.svh"

module soc_gpio
  import soc_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_n,
  input  wb_req_t            req_i,
  input  logic [`GPIO_W-1:0] gpio_i,
  output wb_rsp_t            rsp_o,
  output logic [`GPIO_W-1:0] gpio_o
);

  logic [`GPIO_W-1:0]     out_q;
  logic [`GPIO_W-1:0]     sync1_q;
  logic [`GPIO_W-1:0]     in_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic [`SOC_OFS_W-1:0]  ofs;
  logic                   access;
  logic                   ack_q;

  assign ofs    = req_i.adr[`SOC_OFS_W-1:0];
  assign access = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      ack_q   <= 1'b0;
      out_q   <= '0;
      sync1_q <= '0;
      in_q    <= '0;
    end else begin
      ack_q   <= access;
      // two-flop synchronizer on the pins
      sync1_q <= gpio_i;
      in_q    <= sync1_q;
      if (access && req_i.we && ofs == `GPIO_OUT_OFS && req_i.sel[0]) begin
        out_q <= req_i.dat[`GPIO_W-1:0];
      end
    end
  end

  // read mux where unknown offsets return zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        `GPIO_OUT_OFS: rdata_q <= {{(`SOC_DATA_W-`GPIO_W){1'b0}}, out_q};
        `GPIO_IN_OFS:  rdata_q <= {{(`SOC_DATA_W-`GPIO_W){1'b0}}, in_q};
        default:       rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o  = '{ack: ack_q, err: 1'b0, dat: rdata_q};
  assign gpio_o = out_q;

endmodule

//--- soc_uart_tx.sv
`include "soc_macros.svh"

module soc_uart_tx
  import soc_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_n,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o,
  output logic    tx_o
);

  logic [`UART_DIV_W-1:0] div_q;
  logic [`UART_DIV_W-1:0] baud_cnt_q;
  logic [9:0]             shift_q;
  logic [3:0]             bit_cnt_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic [`SOC_OFS_W-1:0]  ofs;
  logic                   access;
  logic                   data_wr;
  logic                   load_frame;
  logic                   busy;
  logic                   ack_q;

  assign ofs     = req_i.adr[`SOC_OFS_W-1:0];
  assign access  = req_i.cyc & req_i.stb & ~ack_q;
  assign data_wr = access & req_i.we & (ofs == `UART_DATA_OFS);
  assign busy    = (bit_cnt_q != 4'd0);

  // data write stalls until the shifter is free
  assign load_frame = data_wr & ~busy;

  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      ack_q      <= 1'b0;
      div_q      <= `UART_DIV_RESET;
      baud_cnt_q <= '0;
      shift_q    <= '1;
      bit_cnt_q  <= 4'd0;
    end else begin
      ack_q <= access & (~data_wr | ~busy);
      if (access && req_i.we && ofs == `UART_DIV_OFS) begin
        if (req_i.sel[0]) begin
          div_q[7:0] <= req_i.dat[7:0];
        end
        if (req_i.sel[1]) begin
          div_q[15:8] <= req_i.dat[15:8];
        end
      end
      if (load_frame) begin
        // stop, data lsb first, start
        shift_q    <= {1'b1, req_i.dat[7:0], 1'b0};
        bit_cnt_q  <= 4'd10;
        baud_cnt_q <= div_q - 1'b1;
      end else if (busy) begin
        if (baud_cnt_q == '0) begin
          shift_q    <= {1'b1, shift_q[9:1]};
          bit_cnt_q  <= bit_cnt_q - 4'd1;
          baud_cnt_q <= div_q - 1'b1;
        end else begin
          baud_cnt_q <= baud_cnt_q - 1'b1;
        end
      end
    end
  end

  // data register reads as zero
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        `UART_DIV_OFS:  rdata_q <= {{(`SOC_DATA_W-`UART_DIV_W){1'b0}}, div_q};
        `UART_STAT_OFS: rdata_q <= {{(`SOC_DATA_W-1){1'b0}}, busy};
        default:        rdata_q <= '0;
      endcase
    end
  end

  assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdata_q};
  assign tx_o  = shift_q[0];

  // a data write ack comes only with a fresh frame that was loaded from idle
  a_load_idle: assert property (
    @(posedge clk_i) disable iff (!reset_n)
    (ack_q && req_i.we && ofs == `UART_DATA_OFS)
      |-> (bit_cnt_q == 4'd10 && $past(bit_cnt_q) == 4'd0)
  );

endmodule

//--- soc_top.sv
`include "soc_macros.svh"

module soc_top
  import soc_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_n,
  input  wb_req_t            wb_req_i,
  input  logic [`GPIO_W-1:0] gpio_i,
  output wb_rsp_t            wb_rsp_o,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic               tx_o
);

  wb_req_t s_req [`SOC_SLAVES];
  wb_rsp_t s_rsp [`SOC_SLAVES];

  soc_bus_decoder u_decoder (
    .clk_i   (clk_i),
    .reset_n (reset_n),
    .m_req_i (wb_req_i),
    .m_rsp_o (wb_rsp_o),
    .s_req_o (s_req),
    .s_rsp_i (s_rsp)
  );

  soc_sram u_sram (
    .clk_i   (clk_i),
    .reset_n (reset_n),
    .req_i   (s_req[SLV_SRAM]),
    .rsp_o   (s_rsp[SLV_SRAM])
  );

  soc_gpio u_gpio (
    .clk_i   (clk_i),
    .reset_n (reset_n),
    .req_i   (s_req[SLV_GPIO]),
    .gpio_i  (gpio_i),
    .rsp_o   (s_rsp[SLV_GPIO]),
    .gpio_o  (gpio_o)
  );

  soc_uart_tx u_uart_tx (
    .clk_i   (clk_i),
    .reset_n (reset_n),
    .req_i   (s_req[SLV_UART]),
    .rsp_o   (s_rsp[SLV_UART]),
    .tx_o    (tx_o)
  );

endmodule

//--- tb_soc.sv
`include "soc_macros.svh"

module tb_soc
  import soc_pkg::*;
;

  localparam logic [31:0] SEED = 32'h178d18c6;
  // bus accesses issued over all tests rounded up
  localparam int ACCESS_CNT = 85;
  // 12 frames of 10 bits at the largest divisor plus 4 cycles per access
  localparam int LIMIT = 12 * 10 * 8 + ACCESS_CNT * 4;

  logic               clk_i;
  logic               reset_n;
  wb_req_t            wb_req;
  wb_rsp_t            wb_rsp;
  logic [`GPIO_W-1:0] gpio_in;
  logic [`GPIO_W-1:0] gpio_o;
  logic               tx_o;

  logic [31:0] lfsr_q;
  logic [31:0] model_mem [`SRAM_WORDS];
  logic [3:0]  known [`SRAM_WORDS];
  logic [7:0]  exp_q [$];
  int          cur_div;
  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          frames_seen = 0;
  logic        mon_busy = 1'b0;

  soc_top UUT (
    .clk_i    (clk_i),
    .reset_n  (reset_n),
    .wb_req_i (wb_req),
    .gpio_i   (gpio_in),
    .wb_rsp_o (wb_rsp),
    .gpio_o   (gpio_o),
    .tx_o     (tx_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // one classic cycle with the response sampled at the falling edge
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic ack, output logic err,
                           output logic [31:0] rdat, output int waited, output int ack_cyc);
    waited = 0;
    @(posedge clk_i);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    @(negedge clk_i);
    while (!(wb_rsp.ack || wb_rsp.err)) begin
      @(posedge clk_i);
      waited++;
      @(negedge clk_i);
    end
    ack = wb_rsp.ack;
    err = wb_rsp.err;
    rdat = wb_rsp.dat;
    ack_cyc = cycle_cnt;
    @(posedge clk_i);
    wb_req <= '0;
  endtask

  task automatic wait_uart_idle();
    while (exp_q.size() != 0 || mon_busy) begin
      @(posedge clk_i);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (err_cnt == err_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, err_cnt - err_before);
    end
  endtask

  // uart frame monitor sampling mid-bit on falling clock edges
  always begin
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    int         d;
    @(negedge tx_o);
    if (reset_n) begin
      d = cur_div;
      mon_busy = 1'b1;
      repeat ((d + 1) / 2) @(negedge clk_i);
      if (tx_o !== 1'b0) begin
        $display("ERROR %0t: uart start bit is not low", $time);
        err_cnt++;
      end
      for (int i = 0; i < 8; i++) begin
        repeat (d) @(negedge clk_i);
        rx_byte[i] = tx_o;
      end
      repeat (d) @(negedge clk_i);
      if (tx_o !== 1'b1) begin
        $display("ERROR %0t: uart stop bit is not high", $time);
        err_cnt++;
      end
      if (exp_q.size() == 0) begin
        $display("uart sent a frame that no write asked for");
        err_cnt++;
      end else begin
        exp_byte = exp_q.pop_front();
        if (rx_byte !== exp_byte) begin
          $display("ERROR %0t: uart byte %h expected %h", $time, rx_byte, exp_byte);
          err_cnt++;
        end
      end
      frames_seen++;
      mon_busy = 1'b0;
    end
  end

  initial begin
    logic        ack;
    logic        err;
    logic [31:0] rdat;
    int          waited;
    int          c1;
    int          c2;
    int          mark;
    int          frames_before;
    logic [7:0]  widx;
    logic [31:0] adr;
    logic [31:0] wdat;
    logic [31:0] mask;
    logic [3:0]  sel;
    logic        we;
    logic [7:0]  gval;
    logic [7:0]  byte_v;

    clk_i = 1'b0;
    reset_n = 1'b0;
    wb_req = '0;
    gpio_in = '0;
    lfsr_q = SEED;
    cur_div = 4;
    for (int i = 0; i < `SRAM_WORDS; i++) begin
      model_mem[i] = '0;
      known[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    reset_n <= 1'b1;

    mark = err_cnt;
    @(negedge clk_i);
    if (tx_o !== 1'b1 || gpio_o !== 8'h00 || wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0) begin
      $display("ERROR %0t: after reset tx_o %b gpio_o %h ack %b err %b", $time, tx_o,
               gpio_o, wb_rsp.ack, wb_rsp.err);
      err_cnt++;
    end
    wb_access(1'b0, `UART_BASE + 32'h4, '0, 4'hf, ack, err, rdat, waited, c1);
    if (!ack || rdat !== {16'd0, `UART_DIV_RESET}) begin
      $display("ERROR %0t: divisor after reset reads %h", $time, rdat);
      err_cnt++;
    end
    wb_access(1'b0, `UART_BASE + 32'h8, '0, 4'hf, ack, err, rdat, waited, c1);
    if (!ack || rdat !== 32'd0) begin
      $display("ERROR %0t: status after reset reads %h", $time, rdat);
      err_cnt++;
    end
    report_test("reset values", mark);

    // small window so that reads often hit written words
    mark = err_cnt;
    for (int i = 0; i < 64; i++) begin
      widx = {4'd0, 4'(rand_bits(4))};
      we = 1'(rand_bits(1));
      sel = 4'(rand_bits(4));
      wdat = rand_bits(32);
      adr = `SRAM_BASE + {22'd0, widx, 2'b00};
      wb_access(we, adr, wdat, sel, ack, err, rdat, waited, c1);
      if (!ack || err) begin
        $display("ram access to %h ended without ack", adr);
        err_cnt++;
      end
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (sel[b]) begin
            model_mem[widx][b*8 +: 8] = wdat[b*8 +: 8];
          end
        end
        known[widx] = known[widx] | sel;
      end else begin
        for (int b = 0; b < 4; b++) begin
          mask[b*8 +: 8] = {8{known[widx][b]}};
        end
        if ((rdat & mask) !== (model_mem[widx] & mask)) begin
          $display("ERROR %0t: ram %h read %h expected %h", $time, adr, rdat,
                   model_mem[widx]);
          err_cnt++;
        end
      end
    end
    report_test("ram write/read", mark);

    mark = err_cnt;
    wb_access(1'b0, `SRAM_BASE, '0, 4'hf, ack, err, rdat, waited, c1);
    if (!ack || waited != 1) begin
      $display("ERROR %0t: ram latency %0d cycles", $time, waited);
      err_cnt++;
    end
    wb_access(1'b0, `GPIO_BASE, '0, 4'hf, ack, err, rdat, waited, c1);
    if (!ack || waited != 1) begin
      $display("ERROR %0t: gpio latency %0d cycles", $time, waited);
      err_cnt++;
    end
    wb_access(1'b0, 32'h2000_0000, '0, 4'hf, ack, err, rdat, waited, c1);
    if (ack || !err || waited != 1) begin
      $display("ERROR %0t: unmapped access ack %b err %b after %0d cycles", $time, ack, err,
               waited);
      err_cnt++;
    end
    report_test("latency", mark);

    mark = err_cnt;
    gval = 8'(rand_bits(8));
    wb_access(1'b1, `GPIO_BASE, {24'd0, gval}, 4'hf, ack, err, rdat, waited, c1);
    if (gpio_o !== gval) begin
      $display("ERROR %0t: gpio_o %h expected %h", $time, gpio_o, gval);
      err_cnt++;
    end
    wb_access(1'b0, `GPIO_BASE, '0, 4'hf, ack, err, rdat, waited, c1);
    if (rdat !== {24'd0, gval}) begin
      $display("ERROR %0t: gpio output reads %h expected %h", $time, rdat, gval);
      err_cnt++;
    end
    gval = 8'(rand_bits(8));
    @(posedge clk_i);
    gpio_in <= gval;
    repeat (3) @(posedge clk_i);
    wb_access(1'b0, `GPIO_BASE + 32'h4, '0, 4'hf, ack, err, rdat, waited, c1);
    if (rdat !== {24'd0, gval}) begin
      $display("ERROR %0t: gpio input reads %h expected %h", $time, rdat, gval);
      err_cnt++;
    end
    report_test("gpio", mark);

    mark = err_cnt;
    cur_div = 2 + int'(rand_bits(3)) % 7;
    wb_access(1'b1, `UART_BASE + 32'h4, 32'(cur_div), 4'h3, ack, err, rdat, waited, c1);
    wb_access(1'b0, `UART_BASE + 32'h4, '0, 4'hf, ack, err, rdat, waited, c1);
    if (rdat !== 32'(cur_div)) begin
      $display("ERROR %0t: divisor reads %h expected %0d", $time, rdat, cur_div);
      err_cnt++;
    end
    frames_before = frames_seen;
    for (int i = 0; i < 8; i++) begin
      byte_v = 8'(rand_bits(8));
      exp_q.push_back(byte_v);
      wb_access(1'b1, `UART_BASE, {24'd0, byte_v}, 4'h1, ack, err, rdat, waited, c1);
      if (!ack) begin
        $display("uart data write ended without ack");
        err_cnt++;
      end
    end
    wait_uart_idle();
    if (frames_seen - frames_before != 8) begin
      $display("ERROR %0t: %0d uart frames seen, 8 expected", $time,
               frames_seen - frames_before);
      err_cnt++;
    end
    report_test("uart frames", mark);

    mark = err_cnt;
    byte_v = 8'(rand_bits(8));
    exp_q.push_back(byte_v);
    wb_access(1'b1, `UART_BASE, {24'd0, byte_v}, 4'h1, ack, err, rdat, waited, c1);
    wb_access(1'b0, `UART_BASE + 32'h8, '0, 4'hf, ack, err, rdat, waited, c2);
    if (rdat[0] !== 1'b1) begin
      $display("ERROR %0t: status not busy during a frame", $time);
      err_cnt++;
    end
    byte_v = 8'(rand_bits(8));
    exp_q.push_back(byte_v);
    wb_access(1'b1, `UART_BASE, {24'd0, byte_v}, 4'h1, ack, err, rdat, waited, c2);
    if (c2 - c1 < 10 * cur_div) begin
      $display("ERROR %0t: second write acked %0d cycles after the first", $time, c2 - c1);
      err_cnt++;
    end
    wait_uart_idle();
    report_test("back-pressure", mark);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+.
soc_pkg.sv
soc_bus_decoder.sv
soc_sram.sv
soc_gpio.sv
soc_uart_tx.sv
soc_top.sv
tb_soc.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module tb_soc -o tb_soc_sim
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/tb_soc_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All checks passed" "$LOG"; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi
